// ==== core_pkg.sv ====
`default_nettype none

package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [2:0]  reg_idx_t;
    typedef logic [15:0] imm_t;

    localparam int unsigned QUEUE_DEPTH = 4;
    localparam addr_t       RESET_PC    = 32'h0000_0000;

    typedef logic [$clog2(QUEUE_DEPTH+1)-1:0] credit_t; // 0 to QUEUE_DEPTH
    typedef logic [$clog2(QUEUE_DEPTH)-1:0]   qptr_t;

    // Opcode sits in bits 31:28, unknown values run as NOP
    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_ADDI = 4'd1,
        OP_ADD  = 4'd2,
        OP_LW   = 4'd3,
        OP_SW   = 4'd4,
        OP_HALT = 4'd15
    } opcode_e;

    typedef struct packed {
        opcode_e  op;       // 31:28
        logic     rsvd_27;
        reg_idx_t rd;       // 26:24
        logic     rsvd_23;
        reg_idx_t rs;       // 22:20
        logic     rsvd_19;
        reg_idx_t rt;       // 18:16, ADD only
        imm_t     imm;      // 15:0, sign-extended
    } insn_t;

    // Wishbone classic master side
    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        addr_t addr;
        word_t wdata;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        word_t rdata;
    } wb_rsp_t;

endpackage

`default_nettype wire

// ==== pc_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module pc_fetch (
    input  wire logic             clk_core,
    input  wire logic             rst_n_i,
    output core_pkg::wb_req_t     ibus_req_o,
    input  core_pkg::wb_rsp_t     ibus_rsp_i,
    input  wire logic             credit_ret_i,
    output logic                  fq_valid_o,
    output core_pkg::word_t       fq_word_o
);
    import core_pkg::*;

    addr_t   pc_q;
    logic    busy_q;
    credit_t credits_q;

    logic    ack_seen;
    logic    start;

    // Ack only counts while our own request is out
    assign ack_seen = busy_q && ibus_rsp_i.ack;

    // New read when idle or finishing, as long as a queue slot is reserved
    assign start = (credits_q != '0) && (!busy_q || ack_seen);

    always_ff @(posedge clk_core or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q   <= RESET_PC;
            busy_q <= 1'b0;
        end else begin
            if (ack_seen) begin
                pc_q <= pc_q + addr_t'(4); // Next sequential word
            end

            if (start) begin
                busy_q <= 1'b1;
            end else if (ack_seen) begin
                busy_q <= 1'b0;
            end
        end
    end

    // Spend on start, refill on pop; both at once leave the count alone
    always_ff @(posedge clk_core or negedge rst_n_i) begin
        if (!rst_n_i) begin
            credits_q <= credit_t'(QUEUE_DEPTH);
        end else begin
            case ({start, credit_ret_i})
                2'b10:   credits_q <= credits_q - credit_t'(1);
                2'b01:   credits_q <= credits_q + credit_t'(1);
                default: credits_q <= credits_q;
            endcase
        end
    end

    // Read-only bus
    always_comb begin
        ibus_req_o.cyc   = busy_q;
        ibus_req_o.stb   = busy_q;
        ibus_req_o.we    = 1'b0;
        ibus_req_o.addr  = pc_q;
        ibus_req_o.wdata = '0;
    end

    assign fq_valid_o = ack_seen;
    assign fq_word_o  = ibus_rsp_i.rdata;   // Valid in the ack cycle only

endmodule

`default_nettype wire

// ==== insn_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module insn_queue (
    input  wire logic         clk_core,
    input  wire logic         rst_n_i,
    input  wire logic         fq_valid_i,
    input  core_pkg::word_t   fq_word_i,
    input  wire logic         q_pop_i,
    output logic              q_valid_o,
    output core_pkg::word_t   q_word_o,
    output logic              credit_ret_o
);
    import core_pkg::*;

    word_t   mem [QUEUE_DEPTH];
    qptr_t   wr_ptr_q;
    qptr_t   rd_ptr_q;
    credit_t count_q;

    logic    do_pop;

    assign q_valid_o = (count_q != '0);
    assign q_word_o  = mem[rd_ptr_q];
    assign do_pop    = q_pop_i && q_valid_o;

    // Each pop frees a slot, so hand one credit back to fetch
    assign credit_ret_o = do_pop;

    // Storage only, no reset
    always_ff @(posedge clk_core) begin
        if (fq_valid_i) begin
            mem[wr_ptr_q] <= fq_word_i;
        end
    end

    always_ff @(posedge clk_core or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (fq_valid_i) wr_ptr_q <= wr_ptr_q + qptr_t'(1); // Wraps at depth
            if (do_pop)     rd_ptr_q <= rd_ptr_q + qptr_t'(1);

            case ({fq_valid_i, do_pop})
                2'b10:   count_q <= count_q + credit_t'(1);
                2'b01:   count_q <= count_q - credit_t'(1);
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== exec_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input  wire logic         clk_core,
    input  wire logic         rst_n_i,
    input  wire logic         q_valid_i,
    input  core_pkg::word_t   q_word_i,
    output logic              q_pop_o,
    output core_pkg::wb_req_t dbus_req_o,
    input  core_pkg::wb_rsp_t dbus_rsp_i,
    output logic              halted_o
);
    import core_pkg::*;

    typedef enum logic [1:0] {
        EX_RUN,
        EX_MEM,
        EX_HALT
    } ex_state_e;

    ex_state_e state_q;
    word_t     rf [8];

    insn_t     insn;
    word_t     rs_val;
    word_t     rt_val;
    word_t     rd_val;
    word_t     imm_ext;
    word_t     sum;
    logic      mem_ack;

    logic      wr_en;
    reg_idx_t  wr_idx;
    word_t     wr_data;

    // Pending data bus request
    logic      req_vld_q;
    logic      req_we_q;
    addr_t     req_addr_q;
    word_t     req_wdata_q;
    reg_idx_t  ld_rd_q;

    assign insn    = insn_t'(q_word_i);
    assign q_pop_o = (state_q == EX_RUN) && q_valid_i;

    // Register 0 reads as zero
    assign rs_val  = (insn.rs == '0) ? '0 : rf[insn.rs];
    assign rt_val  = (insn.rt == '0) ? '0 : rf[insn.rt];
    assign rd_val  = (insn.rd == '0) ? '0 : rf[insn.rd]; // Store data for SW
    assign imm_ext = {{16{insn.imm[15]}}, insn.imm};
    assign sum     = rs_val + ((insn.op == OP_ADD) ? rt_val : imm_ext); // Also the LW/SW address

    assign mem_ack = (state_q == EX_MEM) && dbus_rsp_i.ack;

    // One write port, ALU result on pop or load data on ack
    always_comb begin
        wr_en   = 1'b0;
        wr_idx  = insn.rd;
        wr_data = sum;
        if (mem_ack) begin
            wr_en   = !req_we_q;
            wr_idx  = ld_rd_q;
            wr_data = dbus_rsp_i.rdata;
        end else if (q_pop_o) begin
            wr_en = (insn.op == OP_ADDI) || (insn.op == OP_ADD);
        end
    end

    always_ff @(posedge clk_core or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 8; i++) begin
                rf[i] <= '0;
            end
        end else if (wr_en && (wr_idx != '0)) begin
            rf[wr_idx] <= wr_data;      // Writes to r0 dropped
        end
    end

    always_ff @(posedge clk_core or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q   <= EX_RUN;
            req_vld_q <= 1'b0;
            req_we_q  <= 1'b0;
        end else begin
            case (state_q)
                EX_RUN: begin
                    if (q_pop_o) begin
                        case (insn.op)
                            OP_LW, OP_SW: begin
                                req_vld_q <= 1'b1;
                                req_we_q  <= (insn.op == OP_SW);
                                state_q   <= EX_MEM;
                            end
                            OP_HALT: state_q <= EX_HALT;
                            default: state_q <= EX_RUN; // ALU ops and NOP
                        endcase
                    end
                end
                EX_MEM: begin
                    if (mem_ack) begin
                        req_vld_q <= 1'b0;
                        state_q   <= EX_RUN;
                    end
                end
                default: state_q <= EX_HALT; // Stuck until reset
            endcase
        end
    end

    // Address and data captured once, held stable until ack
    always_ff @(posedge clk_core) begin
        if (q_pop_o && ((insn.op == OP_LW) || (insn.op == OP_SW))) begin
            req_addr_q  <= sum;
            req_wdata_q <= rd_val;
            ld_rd_q     <= insn.rd;
        end
    end

    always_comb begin
        dbus_req_o.cyc   = req_vld_q;
        dbus_req_o.stb   = req_vld_q;
        dbus_req_o.we    = req_we_q;
        dbus_req_o.addr  = req_addr_q;
        dbus_req_o.wdata = req_wdata_q;
    end

    assign halted_o = (state_q == EX_HALT);

endmodule

`default_nettype wire

// ==== core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_top (
    input  wire logic         clk_core,
    input  wire logic         rst_n_i,
    output core_pkg::wb_req_t ibus_req_o,
    input  core_pkg::wb_rsp_t ibus_rsp_i,
    output core_pkg::wb_req_t dbus_req_o,
    input  core_pkg::wb_rsp_t dbus_rsp_i,
    output logic              halted_o
);
    import core_pkg::*;

    logic  fq_valid;    // Fetch fill into queue
    word_t fq_word;
    logic  credit_ret;
    logic  q_valid;
    word_t q_word;
    logic  q_pop;

    pc_fetch u_fetch (
        .clk_core     (clk_core),
        .rst_n_i      (rst_n_i),
        .ibus_req_o   (ibus_req_o),
        .ibus_rsp_i   (ibus_rsp_i),
        .credit_ret_i (credit_ret),
        .fq_valid_o   (fq_valid),
        .fq_word_o    (fq_word)
    );

    insn_queue u_queue (
        .clk_core     (clk_core),
        .rst_n_i      (rst_n_i),
        .fq_valid_i   (fq_valid),
        .fq_word_i    (fq_word),
        .q_pop_i      (q_pop),
        .q_valid_o    (q_valid),
        .q_word_o     (q_word),
        .credit_ret_o (credit_ret)
    );

    exec_unit u_exec (
        .clk_core     (clk_core),
        .rst_n_i      (rst_n_i),
        .q_valid_i    (q_valid),
        .q_word_i     (q_word),
        .q_pop_o      (q_pop),
        .dbus_req_o   (dbus_req_o),
        .dbus_rsp_i   (dbus_rsp_i),
        .halted_o     (halted_o)
    );

endmodule

`default_nettype wire

// ==== tb_core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_core_top;
    import core_pkg::*;

    typedef struct packed {
        word_t insn;
        logic  st;      // Entry stores to memory
        addr_t addr;
        word_t data;
    } prog_entry_t;

    localparam int PROG_LEN    = 13;
    localparam int WDOG_CYCLES = PROG_LEN * 20 + 200;

    logic        clk_core;
    logic        rst_n;
    wb_req_t     ibus_req;
    wb_rsp_t     ibus_rsp;
    wb_req_t     dbus_req;
    wb_rsp_t     dbus_rsp;
    logic        halted;

    prog_entry_t prog [PROG_LEN];
    prog_entry_t exp_stores [$];
    word_t       imem [addr_t];
    word_t       dmem [addr_t];

    int          seed = 32'haafc_420a;
    int          errors;
    int          checks;
    addr_t       fetch_addr;
    addr_t       halt_addr;
    int          fetch_extra;   // Fetches beyond the HALT word
    logic        ib_pend;
    int unsigned ib_left;
    logic        db_pend;
    int unsigned db_left;
    wb_req_t     db_hold;       // Request as first seen

    core_top DUT (
        .clk_core   (clk_core),
        .rst_n_i    (rst_n),
        .ibus_req_o (ibus_req),
        .ibus_rsp_i (ibus_rsp),
        .dbus_req_o (dbus_req),
        .dbus_rsp_i (dbus_rsp),
        .halted_o   (halted)
    );

    function automatic word_t encode_insn(input opcode_e op, input logic [2:0] rd,
                                          input logic [2:0] rs, input logic [2:0] rt,
                                          input logic [15:0] imm);
        return {op, 1'b0, rd, 1'b0, rs, 1'b0, rt, imm};
    endfunction

    // Unwritten words decode as stores, so a runaway core shows up as a bad store
    function automatic word_t imem_read(input addr_t a);
        if (imem.exists(a)) return imem[a];
        return {OP_SW, a[27:0] ^ {24'h0, a[31:28]}};
    endfunction

    function automatic word_t dmem_read(input addr_t a);
        if (dmem.exists(a)) return dmem[a];
        return a ^ 32'h5a5a_a5a5;
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s expected %h got %h", name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s expected %h got %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s expected %h got %h", name, exp, act);
        end
    endtask

    task automatic match_store(input addr_t a, input word_t d);
        prog_entry_t e;
        if (exp_stores.size() == 0) begin
            errors++;
            $display("Store to %h is not in the program table", a);
        end else begin
            e = exp_stores.pop_front();
            check_addr("dbus_req.addr (store)", e.addr, a);
            check_word("dbus_req.wdata (store)", e.data, d);
        end
    endtask

    task automatic finish_run();
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    initial begin
        clk_core = 1'b0;
        forever #5 clk_core = ~clk_core;
    end

    // Both bus slaves ack after 0 to 3 random wait cycles
    always @(posedge clk_core) begin
        int unsigned d;
        if (!rst_n) begin
            ibus_rsp <= '0;
            dbus_rsp <= '0;
            ib_pend  <= 1'b0;
            db_pend  <= 1'b0;
        end else begin
            ibus_rsp.ack <= 1'b0;
            dbus_rsp.ack <= 1'b0;

            if (ibus_req.cyc && ibus_req.stb && !ibus_rsp.ack) begin
                if (!ib_pend) begin
                    check_addr("ibus_req.addr", fetch_addr, ibus_req.addr);
                    check_flag("ibus_req.we", 1'b0, ibus_req.we);
                    check_word("ibus_req.wdata", '0, ibus_req.wdata);
                    if (ibus_req.addr > halt_addr) fetch_extra++;
                    fetch_addr = fetch_addr + 32'd4;
                    d = $unsigned($random(seed)) % 4;
                end else begin
                    d = ib_left;
                end
                if (d == 0) begin
                    ibus_rsp.ack   <= 1'b1;
                    ibus_rsp.rdata <= imem_read(ibus_req.addr);
                    ib_pend        <= 1'b0;
                end else begin
                    ib_pend <= 1'b1;
                    ib_left <= d - 1;
                end
            end

            if (dbus_req.cyc && dbus_req.stb && !dbus_rsp.ack) begin
                if (!db_pend) begin
                    if (halted) begin
                        errors++;
                        $display("Data bus access to %h started after halt", dbus_req.addr);
                    end
                    db_hold <= dbus_req;
                    d = $unsigned($random(seed)) % 4;
                end else begin
                    check_flag("dbus_req.we", db_hold.we, dbus_req.we);
                    check_addr("dbus_req.addr", db_hold.addr, dbus_req.addr);
                    check_word("dbus_req.wdata", db_hold.wdata, dbus_req.wdata);
                    d = db_left;
                end
                if (d == 0) begin
                    dbus_rsp.ack <= 1'b1;
                    db_pend      <= 1'b0;
                    if (dbus_req.we) begin
                        dbus_rsp.rdata <= '0;
                        dmem[dbus_req.addr] = dbus_req.wdata;
                        match_store(dbus_req.addr, dbus_req.wdata);
                    end else begin
                        dbus_rsp.rdata <= dmem_read(dbus_req.addr);
                    end
                end else begin
                    db_pend <= 1'b1;
                    db_left <= d - 1;
                end
            end
        end
    end

    initial begin
        rst_n    <= 1'b0;
        ibus_rsp <= '0;
        dbus_rsp <= '0;
        fetch_addr  = RESET_PC;
        halt_addr   = '1;
        fetch_extra = 0;

        prog[0]  = '{encode_insn(OP_ADDI, 3'd1, 3'd0, 3'd0, 16'h0010), 1'b0, '0, '0};
        prog[1]  = '{encode_insn(OP_ADDI, 3'd2, 3'd1, 3'd0, 16'hffff), 1'b0, '0, '0};
        prog[2]  = '{encode_insn(OP_ADD,  3'd3, 3'd1, 3'd2, 16'h0000), 1'b0, '0, '0};
        prog[3]  = '{encode_insn(OP_ADDI, 3'd0, 3'd1, 3'd0, 16'h0005), 1'b0, '0, '0};
        prog[4]  = '{encode_insn(OP_SW,   3'd3, 3'd0, 3'd0, 16'h0200), 1'b1,
                     32'h0000_0200, 32'h0000_001f};
        prog[5]  = '{encode_insn(OP_SW,   3'd0, 3'd1, 3'd0, 16'h0204), 1'b1,
                     32'h0000_0214, 32'h0000_0000};     // r0 still zero
        prog[6]  = '{encode_insn(OP_LW,   3'd4, 3'd0, 3'd0, 16'h0100), 1'b0, '0, '0};
        prog[7]  = '{encode_insn(OP_SW,   3'd4, 3'd0, 3'd0, 16'h0208), 1'b1,
                     32'h0000_0208, 32'hcafe_0123};
        prog[8]  = '{encode_insn(OP_LW,   3'd5, 3'd1, 3'd0, 16'h00f4), 1'b0, '0, '0};
        prog[9]  = '{encode_insn(OP_ADDI, 3'd6, 3'd5, 3'd0, 16'hfff0), 1'b0, '0, '0};
        prog[10] = '{encode_insn(OP_SW,   3'd6, 3'd1, 3'd0, 16'h01fc), 1'b1,
                     32'h0000_020c, 32'h1234_5668};
        prog[11] = '{32'h7123_4567, 1'b0, '0, '0};     // Undefined opcode
        prog[12] = '{encode_insn(OP_HALT, 3'd0, 3'd0, 3'd0, 16'h0000), 1'b0, '0, '0};

        for (int i = 0; i < PROG_LEN; i++) begin
            imem[RESET_PC + addr_t'(4 * i)] = prog[i].insn;
            if (prog[i].insn[31:28] == OP_HALT) halt_addr = RESET_PC + addr_t'(4 * i);
            if (prog[i].st) exp_stores.push_back(prog[i]);
        end
        dmem[32'h0000_0100] = 32'hcafe_0123;
        dmem[32'h0000_0104] = 32'h1234_5678;

        repeat (2) begin
            @(negedge clk_core);
            check_flag("ibus_req.cyc", 1'b0, ibus_req.cyc);
            check_flag("dbus_req.cyc", 1'b0, dbus_req.cyc);
            check_flag("halted_o", 1'b0, halted);
        end
        @(posedge clk_core);
        rst_n <= 1'b1;
        @(negedge clk_core);
        check_flag("dbus_req.cyc", 1'b0, dbus_req.cyc);
        check_flag("halted_o", 1'b0, halted);

        while (!halted) @(negedge clk_core);
        @(negedge clk_core);                        // Credit from the HALT pop may start one more
        while (ibus_req.cyc) @(negedge clk_core);   // Fetch stays idle once credits run out
        check_flag("halted_o", 1'b1, halted);
        if (exp_stores.size() != 0) begin
            errors++;
            $display("%0d expected stores never happened", exp_stores.size());
        end
        if (fetch_extra > QUEUE_DEPTH) begin
            errors++;
            $display("%0d fetches were issued past the HALT word", fetch_extra);
        end
        finish_run();
    end

    initial begin
        repeat (WDOG_CYCLES) @(posedge clk_core);
        errors++;
        $display("Program did not halt within %0d cycles", WDOG_CYCLES);
        finish_run();
    end

endmodule

`default_nettype wire

// ==== core_harness.f ====
core_pkg.sv
pc_fetch.sv
insn_queue.sv
exec_unit.sv
core_top.sv
tb_core_top.sv

// ==== run_sim.sh ====
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module tb_core_top -f core_harness.f -o tb_core_top
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_core_top)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^TEST PASS$"; then
    exit 0
fi
exit 1
